// File: compile.f
+incdir+rtl
rtl/dmaPkg.sv
rtl/memBusIf.sv
rtl/busArbiter.sv
rtl/wordFifo.sv
rtl/dmaBusMaster.sv
rtl/sramTarget.sv
rtl/dmaTop.sv
verification/dmaTb.sv

// File: Makefile
VERILATOR = verilator
VFLAGS    = --binary --timing --assert -j 0
TOP       = dmaTb
FILELIST  = compile.f

OBJDIR  = obj_dir
SIM     = $(OBJDIR)/V$(TOP)
LOG     = sim.log
SOURCES = $(filter-out +%,$(shell cat $(FILELIST)))
HEADERS = $(wildcard rtl/*.svh)

.PHONY: all run check clean

all: check

$(SIM): $(FILELIST) $(SOURCES) $(HEADERS)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJDIR) -f $(FILELIST)

run: $(SIM)
	./$(SIM) | tee $(LOG)

check: run
	@grep -q "SIMULATION PASSED" $(LOG) || (echo "check failed, see $(LOG)"; exit 1)

clean:
	rm -rf $(OBJDIR) $(LOG)

// File: verification/dmaTb.sv
// DMA subsystem testbench with stimulus table, reference memory and checks
`timescale 1ns/1ps
`include "dmaDefs_defs.svh"

module dmaTb;
    localparam logic [2:0] opHostWrite  = 3'd0;
    localparam logic [2:0] opHostRead   = 3'd1;
    localparam logic [2:0] opDmaToMem   = 3'd2;
    localparam logic [2:0] opDmaFromMem = 3'd3;
    localparam logic [2:0] opMixed      = 3'd4;  // Read block with host traffic alongside
    localparam int numTests      = 13;
    localparam int timeoutCycles = 2000;

    typedef struct packed {
        logic [2:0]              op;
        logic [`ADDR_WIDTH-1:0]  addr;
        logic [`COUNT_WIDTH-1:0] count;  // Halfwords for host ops in the 16-bit region
        logic [31:0]             seed;
        logic                    bp;     // Random gaps on the stream side
    } testEntry;

    testEntry testTable [numTests] = '{
        '{opHostWrite,  10'h000, 8'd16, 32'h1111_0000, 1'b0},
        '{opHostRead,   10'h000, 8'd16, 32'h0000_0000, 1'b0},
        '{opDmaFromMem, 10'h000, 8'd6,  32'h0000_0000, 1'b0},
        '{opDmaToMem,   10'h200, 8'd6,  32'h2222_0000, 1'b0},
        '{opHostRead,   10'h200, 8'd12, 32'h0000_0000, 1'b0},
        '{opDmaFromMem, 10'h200, 8'd6,  32'h0000_0000, 1'b0},
        '{opHostWrite,  10'h100, 8'd20, 32'h3333_0000, 1'b0},
        '{opMixed,      10'h000, 8'd12, 32'h4444_0000, 1'b1},
        '{opDmaToMem,   10'h040, 8'd20, 32'h5555_0000, 1'b1},
        '{opDmaFromMem, 10'h040, 8'd20, 32'h0000_0000, 1'b1},
        '{opDmaToMem,   10'h300, 8'd12, 32'h6666_0000, 1'b1},
        '{opDmaFromMem, 10'h300, 8'd12, 32'h0000_0000, 1'b1},
        '{opHostRead,   10'h100, 8'd20, 32'h0000_0000, 1'b0}
    };

    logic                    CLK;
    logic                    nRESET;
    logic                    startReq, startAck, dirToMem, busy;
    logic [`ADDR_WIDTH-1:0]  startAddr, hostAddr;
    logic [`COUNT_WIDTH-1:0] wordCount;
    logic [31:0]             fifoInData, fifoOutData, hostWData, hostRData;
    logic                    fifoInValid, fifoInReady, fifoOutValid, fifoOutTaken;
    logic                    hostReq, hostAck, hostWrite;
    logic [31:0]             refMem [`MEM_WORDS];  // Mirror of every write made here
    int                      seed = 59600;
    int                      checks = 0;
    int                      errors = 0;
    int                      timeouts = 0;
    bit                      abortRun = 1'b0;

    dmaTop u_dmaTop (.*);

    initial begin
        CLK = 1'b0;
        forever #2 CLK = ~CLK;
    end

    task automatic waitCycle(inout int waited, input string what);
        @(negedge CLK);
        waited++;
        if (waited > timeoutCycles && !abortRun) begin
            $display("timeout at %0t: %s", $time, what);
            timeouts++;
            abortRun = 1'b1;
        end
    endtask

    function automatic void storeRef(input int a, input logic [31:0] w);
        if (!a[`NARROW_BIT]) begin
            refMem[a / 4] = w;
        end else if (a[1]) begin
            refMem[a / 4][31:16] = w[15:0];  // 16-bit port takes data 15:0 only
        end else begin
            refMem[a / 4][15:0] = w[15:0];
        end
    endfunction

    function automatic logic [31:0] expectRead(input int a);
        logic [31:0] w;
        w = refMem[a / 4];
        if (!a[`NARROW_BIT]) begin
            return w;
        end
        return {16'h0000, a[1] ? w[31:16] : w[15:0]};
    endfunction

    task automatic hostRun(input logic write, input int addr, input int count,
                           input logic [31:0] seedW);
        int          a;
        int          waited;
        logic [31:0] word;
        for (int i = 0; i < count && !abortRun; i++) begin
            a         = addr + i * (addr[`NARROW_BIT] ? 2 : 4);  // Halfword steps when narrow
            word      = $random(seed) ^ seedW;
            waited    = 0;
            hostReq   = 1'b1;
            hostWrite = write;
            hostAddr  = `ADDR_WIDTH'(a);
            hostWData = word;
            while (!hostAck && !abortRun) begin
                waitCycle(waited, "host access was never acknowledged");
            end
            if (write) begin
                storeRef(a, word);
            end else begin
                checks++;
                if (hostRData !== expectRead(a)) begin
                    errors++;
                    $display("mismatch at %0t: hostRData addr %h expected %h actual %h",
                             $time, a, expectRead(a), hostRData);
                end
            end
            hostReq = 1'b0;
            waited  = 0;
            while (hostAck && !abortRun) begin
                waitCycle(waited, "hostAck did not fall after hostReq fell");
            end
            @(negedge CLK);  // Idle cycle lets the arbiter release the bus
        end
    endtask

    task automatic dmaBlock(input logic toMem, input int addr, input int count,
                            input logic [31:0] seedW, input logic bp);
        logic [31:0] words [`MEM_WORDS];
        int          moved;
        int          waited;
        for (int i = 0; i < count; i++) begin
            words[i] = $random(seed) ^ seedW;
        end
        dirToMem  = toMem;
        startAddr = `ADDR_WIDTH'(addr);
        wordCount = `COUNT_WIDTH'(count);
        startReq  = 1'b1;
        moved     = 0;
        waited    = 0;
        @(negedge CLK);
        while (!(startAck && moved == count) && !abortRun) begin
            fifoInValid  = 1'b0;
            fifoOutTaken = 1'b0;
            if (moved < count && (!bp || ($random(seed) & 3) != 0)) begin
                if (toMem && fifoInReady) begin
                    fifoInValid = 1'b1;
                    fifoInData  = words[moved];
                    moved++;
                end else if (!toMem && fifoOutValid) begin
                    checks++;
                    if (fifoOutData !== refMem[addr / 4 + moved]) begin
                        errors++;
                        $display("mismatch at %0t: fifoOutData word %0d expected %h actual %h",
                                 $time, moved, refMem[addr / 4 + moved], fifoOutData);
                    end
                    fifoOutTaken = 1'b1;
                    moved++;
                end
            end
            waitCycle(waited, "DMA block did not move every word and raise startAck");
        end
        fifoInValid  = 1'b0;
        fifoOutTaken = 1'b0;
        for (int i = 0; i < count && toMem; i++) begin
            storeRef(addr + 4 * i, words[i]);
            if (addr[`NARROW_BIT]) begin
                storeRef(addr + 4 * i + 2, words[i] >> 16);  // Upper half in the second cycle
            end
        end
        startReq = 1'b0;
        waited   = 0;
        while (startAck && !abortRun) begin
            waitCycle(waited, "startAck did not fall after startReq fell");
        end
        checks++;
        if (busy !== 1'b0) begin
            errors++;
            $display("mismatch at %0t: busy expected 0 actual %b", $time, busy);
        end
        if (!toMem) begin
            checks++;
            if (fifoOutValid !== 1'b0) begin
                errors++;
                $display("FIFO still holds words after the read block ended at %0t", $time);
            end
        end
    endtask

    initial begin
        testEntry e;
        nRESET = 1'b0;
        {startReq, dirToMem, fifoInValid, fifoOutTaken, hostReq, hostWrite} = '0;
        {startAddr, wordCount, fifoInData, hostAddr, hostWData} = '0;
        repeat (16) @(negedge CLK);
        nRESET = 1'b1;
        @(negedge CLK);
        checks++;
        if ({hostAck, startAck, busy, fifoOutValid, fifoInReady} !== 5'b00001) begin
            errors++;
            $display("mismatch at %0t: reset outputs expected %b actual %b", $time, 5'b00001,
                     {hostAck, startAck, busy, fifoOutValid, fifoInReady});
        end
        for (int t = 0; t < numTests && !abortRun; t++) begin
            e = testTable[t];
            case (e.op)
                opHostWrite:  hostRun(1'b1, e.addr, e.count, e.seed);
                opHostRead:   hostRun(1'b0, e.addr, e.count, e.seed);
                opDmaToMem:   dmaBlock(1'b1, e.addr, e.count, e.seed, e.bp);
                opDmaFromMem: dmaBlock(1'b0, e.addr, e.count, e.seed, e.bp);
                opMixed: begin
                    fork
                        dmaBlock(1'b0, e.addr, e.count, e.seed, e.bp);
                        begin
                            hostRun(1'b1, 'h180, 8, e.seed);  // Region apart from the block
                            hostRun(1'b0, 'h180, 8, e.seed);
                        end
                    join
                end
                default: begin
                    errors++;
                    $display("unknown operation in table entry %0d", t);
                end
            endcase
        end
        $display("checks %0d, errors %0d, timeouts %0d", checks, errors, timeouts);
        if (errors == 0 && timeouts == 0) begin
            $display("SIMULATION PASSED");
        end else begin
            $display("SIMULATION FAILED");
        end
        $finish;
    end

endmodule

// File: rtl/dmaTop.sv
// DMA subsystem top with master, shared FIFO, arbiter and memory target
`timescale 1ns/1ps
`include "dmaDefs_defs.svh"

module dmaTop (
    input  logic                    CLK,
    input  logic                    nRESET,
    input  logic                    startReq,
    output logic                    startAck,
    input  logic                    dirToMem,
    input  logic [`ADDR_WIDTH-1:0]  startAddr,
    input  logic [`COUNT_WIDTH-1:0] wordCount,
    output logic                    busy,
    input  logic [31:0]             fifoInData,
    input  logic                    fifoInValid,
    output logic                    fifoInReady,
    output logic [31:0]             fifoOutData,
    output logic                    fifoOutValid,
    input  logic                    fifoOutTaken,
    input  logic                    hostReq,
    output logic                    hostAck,
    input  logic                    hostWrite,
    input  logic [`ADDR_WIDTH-1:0]  hostAddr,
    input  logic [31:0]             hostWData,
    output logic [31:0]             hostRData
);
    memBusIf dmaBus ();
    memBusIf hostBus ();
    memBusIf memBus ();

    dmaPkg::fifoWord masterPushData;
    dmaPkg::fifoWord fifoPushData;
    dmaPkg::fifoWord fifoPopData;
    logic            masterPush;
    logic            masterPop;
    logic            fifoPush;
    logic            fifoPop;
    logic            fifoFull;
    logic            fifoEmpty;
    logic            fifoFlush;
    logic            streamOwnsPush;

    // Stream-in feeds the FIFO except during a read block
    assign streamOwnsPush        = dirToMem | ~busy;
    assign fifoInReady           = streamOwnsPush & ~fifoFull;
    assign fifoPush              = streamOwnsPush ? (fifoInValid & ~fifoFull) : masterPush;
    assign fifoPushData.longWord = streamOwnsPush ? fifoInData : masterPushData.longWord;
    assign fifoOutValid          = ~dirToMem & ~fifoEmpty;
    assign fifoOutData           = fifoPopData.longWord;
    assign fifoPop               = dirToMem ? masterPop : (fifoOutValid & fifoOutTaken);
    assign fifoFlush             = startReq & ~busy & ~dirToMem;  // Read blocks start empty

    assign hostBus.req   = hostReq;
    assign hostBus.write = hostWrite;
    assign hostBus.addr  = hostAddr;
    assign hostBus.wdata = hostWData;
    assign hostBus.half  = 1'b0;
    assign hostAck       = hostBus.ack;
    assign hostRData     = hostBus.rdata;

    dmaBusMaster u_dmaBusMaster (
        .CLK(CLK), .nRESET(nRESET),
        .startReq(startReq), .startAck(startAck), .dirToMem(dirToMem),
        .startAddr(startAddr), .wordCount(wordCount), .busy(busy),
        .fifoPush(masterPush), .fifoPushData(masterPushData), .fifoFull(fifoFull),
        .fifoPop(masterPop), .fifoPopData(fifoPopData), .fifoEmpty(fifoEmpty),
        .bus(dmaBus.requester)
    );

    wordFifo u_wordFifo (
        .CLK(CLK), .nRESET(nRESET), .flush(fifoFlush),
        .pushData(fifoPushData), .push(fifoPush), .full(fifoFull),
        .popData(fifoPopData), .pop(fifoPop), .empty(fifoEmpty)
    );

    busArbiter u_busArbiter (
        .CLK(CLK), .nRESET(nRESET),
        .dma(dmaBus.arbiter), .host(hostBus.arbiter), .mem(memBus.requester)
    );

    sramTarget u_sramTarget (.CLK(CLK), .nRESET(nRESET), .bus(memBus.target));

endmodule

// File: rtl/sramTarget.sv
// Memory target answering as a 32-bit or 16-bit port by address region
`timescale 1ns/1ps
`include "dmaDefs_defs.svh"

module sramTarget (
    input  logic    CLK,
    input  logic    nRESET,
    memBusIf.target bus
);
    localparam int idxWidth   = $clog2(`MEM_WORDS);
    localparam int delayWidth = $clog2(`ACK_DELAY + 1);

    logic [31:0]           memArray [`MEM_WORDS];
    logic [idxWidth-1:0]   wordIdx;
    logic [delayWidth-1:0] delayCnt;
    logic                  narrow;
    logic                  fire;  // Access happens with the ack edge

    assign wordIdx = bus.addr[`ADDR_WIDTH-1:2];
    assign narrow  = bus.addr[`NARROW_BIT] | bus.half;
    assign fire    = bus.req && !bus.ack && (delayCnt == delayWidth'(`ACK_DELAY - 1));

    always_ff @(posedge CLK or negedge nRESET) begin
        if (!nRESET) begin
            bus.ack       <= 1'b0;
            bus.ackNarrow <= 1'b0;
            delayCnt      <= '0;
        end else if (fire) begin
            bus.ack       <= 1'b1;
            bus.ackNarrow <= narrow;
            delayCnt      <= '0;
        end else if (bus.req && !bus.ack) begin
            delayCnt <= delayCnt + 1'b1;
        end else if (bus.ack && !bus.req) begin
            bus.ack       <= 1'b0;
            bus.ackNarrow <= 1'b0;
        end
    end

    always_ff @(posedge CLK) begin
        if (fire) begin
            if (bus.write) begin
                if (!narrow) begin
                    memArray[wordIdx] <= bus.wdata;
                end else if (bus.addr[1]) begin
                    memArray[wordIdx][31:16] <= bus.wdata[15:0];
                end else begin
                    memArray[wordIdx][15:0] <= bus.wdata[15:0];
                end
            end else if (!narrow) begin
                bus.rdata <= memArray[wordIdx];
            end else begin
                bus.rdata <= {16'h0000, bus.addr[1] ? memArray[wordIdx][31:16]
                                                    : memArray[wordIdx][15:0]};
            end
        end
    end

endmodule

// File: rtl/dmaBusMaster.sv
// DMA bus master FSM running word or split-halfword cycles between FIFO and memory
`timescale 1ns/1ps
`include "dmaDefs_defs.svh"

module dmaBusMaster (
    input  logic                    CLK,
    input  logic                    nRESET,
    input  logic                    startReq,
    output logic                    startAck,
    input  logic                    dirToMem,
    input  logic [`ADDR_WIDTH-1:0]  startAddr,
    input  logic [`COUNT_WIDTH-1:0] wordCount,
    output logic                    busy,
    output logic                    fifoPush,
    output dmaPkg::fifoWord         fifoPushData,
    input  logic                    fifoFull,
    output logic                    fifoPop,
    input  dmaPkg::fifoWord         fifoPopData,
    input  logic                    fifoEmpty,
    memBusIf.requester              bus
);
    dmaPkg::masterState      state;
    logic                    dirReg;    // Latched transfer direction
    logic [`COUNT_WIDTH-1:0] countReg;  // Words still to move
    logic [`ADDR_WIDTH-1:0]  addrReg;
    dmaPkg::fifoWord         wordReg;   // Read data being assembled
    logic                    reqReg;
    logic                    halfReg;
    logic                    startLatch;
    logic                    canStart;
    logic                    firstAck;
    logic                    highAck;
    logic                    wordDone;

    assign startLatch = (state == dmaPkg::stIdle) && startReq;
    assign canStart   = dirReg ? !fifoEmpty : !fifoFull;
    assign firstAck   = (state == dmaPkg::stWaitGrant) && bus.ack;
    assign highAck    = (state == dmaPkg::stHighCycle) && bus.ack;
    assign wordDone   = (state == dmaPkg::stRelease) && !bus.ack && (dirReg || !fifoFull);

    assign busy         = (state != dmaPkg::stIdle);
    assign fifoPush     = wordDone && !dirReg;
    assign fifoPop      = wordDone && dirReg;  // Only after the last half
    assign fifoPushData = wordReg;

    assign bus.req   = reqReg;
    assign bus.write = dirReg;
    assign bus.half  = halfReg;
    assign bus.addr  = halfReg ? addrReg + `ADDR_WIDTH'(2) : addrReg;
    assign bus.wdata = halfReg ? {16'h0000, fifoPopData.halves.upper} : fifoPopData.longWord;

    always_ff @(posedge CLK or negedge nRESET) begin
        if (!nRESET) begin
            state    <= dmaPkg::stIdle;
            dirReg   <= 1'b0;
            countReg <= '0;
            reqReg   <= 1'b0;
            halfReg  <= 1'b0;
            startAck <= 1'b0;
        end else begin
            case (state)
                dmaPkg::stIdle: begin
                    if (startReq) begin
                        dirReg   <= dirToMem;
                        countReg <= wordCount;
                        state    <= (wordCount == '0) ? dmaPkg::stDone : dmaPkg::stWaitData;
                    end
                end
                dmaPkg::stWaitData: begin
                    if (canStart) begin
                        reqReg <= 1'b1;
                        state  <= dmaPkg::stWaitGrant;
                    end
                end
                dmaPkg::stWaitGrant: begin
                    if (bus.ack) begin
                        reqReg <= 1'b0;
                        state  <= bus.ackNarrow ? dmaPkg::stLowCycle : dmaPkg::stRelease;
                    end
                end
                dmaPkg::stLowCycle: begin
                    if (!bus.ack) begin
                        reqReg  <= 1'b1;  // Upper half at address plus 2
                        halfReg <= 1'b1;
                        state   <= dmaPkg::stHighCycle;
                    end
                end
                dmaPkg::stHighCycle: begin
                    if (bus.ack) begin
                        reqReg  <= 1'b0;
                        halfReg <= 1'b0;
                        state   <= dmaPkg::stRelease;
                    end
                end
                dmaPkg::stRelease: begin
                    if (wordDone) begin
                        countReg <= countReg - `COUNT_WIDTH'(1);
                        state    <= (countReg == `COUNT_WIDTH'(1)) ?
                                    dmaPkg::stDone : dmaPkg::stWaitData;
                    end
                end
                dmaPkg::stDone: begin
                    if (startReq) begin
                        startAck <= 1'b1;
                    end else begin
                        startAck <= 1'b0;
                        state    <= dmaPkg::stIdle;
                    end
                end
                default: state <= dmaPkg::stIdle;
            endcase
        end
    end

    always_ff @(posedge CLK) begin
        if (startLatch) begin
            addrReg <= startAddr;
        end else if (wordDone) begin
            addrReg <= addrReg + `ADDR_WIDTH'(4);
        end
        if (firstAck) begin
            wordReg.longWord <= bus.rdata;  // Lower half is right either way
        end
        if (highAck) begin
            wordReg.halves.upper <= bus.rdata[15:0];
        end
    end

    reqHeldUntilAck: assert property (@(posedge CLK) disable iff (!nRESET)
        bus.req && !bus.ack |=> bus.req);
    addrStableInReq: assert property (@(posedge CLK) disable iff (!nRESET)
        bus.req |=> !bus.req || $stable(bus.addr));

endmodule

// File: rtl/wordFifo.sv
// Synchronous 32-bit word FIFO with full, empty and single-cycle flush
`timescale 1ns/1ps
`include "dmaDefs_defs.svh"

module wordFifo (
    input  logic            CLK,
    input  logic            nRESET,
    input  logic            flush,
    input  dmaPkg::fifoWord pushData,
    input  logic            push,
    output logic            full,
    output dmaPkg::fifoWord popData,
    input  logic            pop,
    output logic            empty
);
    localparam int ptrWidth = $clog2(`FIFO_DEPTH);
    localparam logic [ptrWidth:0] depthCount = `FIFO_DEPTH;

    dmaPkg::fifoWord     buffer [`FIFO_DEPTH];
    logic [ptrWidth-1:0] rdPtr;
    logic [ptrWidth-1:0] wrPtr;
    logic [ptrWidth:0]   count;
    logic                doPush;
    logic                doPop;

    assign full    = (count == depthCount);
    assign empty   = (count == '0);
    assign doPush  = push & ~full;
    assign doPop   = pop & ~empty;
    assign popData = buffer[rdPtr];  // Head is visible before the pop

    always_ff @(posedge CLK or negedge nRESET) begin
        if (!nRESET) begin
            rdPtr <= '0;
            wrPtr <= '0;
            count <= '0;
        end else if (flush) begin
            rdPtr <= '0;
            wrPtr <= '0;
            count <= '0;
        end else begin
            if (doPush) begin
                wrPtr <= wrPtr + 1'b1;  // Depth is a power of two
            end
            if (doPop) begin
                rdPtr <= rdPtr + 1'b1;
            end
            case ({doPush, doPop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    always_ff @(posedge CLK) begin
        if (doPush) begin
            buffer[wrPtr] <= pushData;
        end
    end

    // Both stream sides and the master must honour the flags
    noPushWhenFull: assert property (@(posedge CLK) disable iff (!nRESET)
        push |-> !full);
    noPopWhenEmpty: assert property (@(posedge CLK) disable iff (!nRESET)
        pop |-> !empty);

endmodule

// File: rtl/busArbiter.sv
// Fixed-priority two-requester arbiter holding the grant for a full handshake
`timescale 1ns/1ps

module busArbiter (
    input  logic       CLK,
    input  logic       nRESET,
    memBusIf.arbiter   dma,
    memBusIf.arbiter   host,
    memBusIf.requester mem
);
    localparam logic [1:0] ownNone = 2'd0;
    localparam logic [1:0] ownDma  = 2'd1;
    localparam logic [1:0] ownHost = 2'd2;

    logic [1:0] owner;
    logic       dmaOwns;
    logic       hostOwns;

    assign dmaOwns  = (owner == ownDma);
    assign hostOwns = (owner == ownHost);

    always_ff @(posedge CLK or negedge nRESET) begin
        if (!nRESET) begin
            owner <= ownNone;
        end else if (owner == ownNone) begin
            if (dma.req) begin
                owner <= ownDma;  // DMA wins a tie
            end else if (host.req) begin
                owner <= ownHost;
            end
        end else if (!mem.req && !mem.ack) begin
            owner <= ownNone;  // Four-phase cycle finished
        end
    end

    assign mem.req   = dmaOwns ? dma.req   : (hostOwns & host.req);
    assign mem.write = dmaOwns ? dma.write : (hostOwns & host.write);
    assign mem.half  = dmaOwns ? dma.half  : (hostOwns & host.half);
    assign mem.addr  = dmaOwns ? dma.addr  : (hostOwns ? host.addr : '0);
    assign mem.wdata = dmaOwns ? dma.wdata : (hostOwns ? host.wdata : '0);

    assign dma.ack        = dmaOwns & mem.ack;
    assign dma.ackNarrow  = dmaOwns & mem.ackNarrow;
    assign dma.rdata      = dmaOwns ? mem.rdata : '0;
    assign host.ack       = hostOwns & mem.ack;
    assign host.ackNarrow = hostOwns & mem.ackNarrow;
    assign host.rdata     = hostOwns ? mem.rdata : '0;

    // An ack from the target must always reach the requester that owns the cycle
    ackHasOwner: assert property (@(posedge CLK) disable iff (!nRESET)
        mem.ack |-> (dmaOwns || hostOwns));

endmodule

// File: rtl/memBusIf.sv
// Memory bus interface with requester, arbiter and target modports
`timescale 1ns/1ps
`include "dmaDefs_defs.svh"

interface memBusIf;
    logic                   req;
    logic                   write;
    logic [`ADDR_WIDTH-1:0] addr;
    logic [31:0]            wdata;
    logic                   half;       // Upper halfword of a split word
    logic                   ack;
    logic                   ackNarrow;  // Only data 15:0 was taken
    logic [31:0]            rdata;

    modport requester (
        output req, write, addr, wdata, half,
        input  ack, ackNarrow, rdata
    );

    modport arbiter (
        input  req, write, addr, wdata, half,
        output ack, ackNarrow, rdata
    );

    modport target (
        input  req, write, addr, wdata, half,
        output ack, ackNarrow, rdata
    );
endinterface

// File: rtl/dmaPkg.sv
// FIFO word union and DMA master state encoding
package dmaPkg;

    // Halfword view used for split cycles on the 16-bit port
    typedef struct packed {
        logic [15:0] upper;
        logic [15:0] lower;
    } halfPair;

    typedef union packed {
        logic [31:0] longWord;
        halfPair     halves;
    } fifoWord;

    // Master states, one bus cycle per word or two per split word
    typedef enum logic [2:0] {
        stIdle      = 3'd0,
        stWaitGrant = 3'd1,  // First cycle requested, waiting for ack
        stWaitData  = 3'd2,  // FIFO not ready for the next word
        stLowCycle  = 3'd3,  // Narrow ack seen, waiting for ack low
        stHighCycle = 3'd4,  // Upper halfword cycle
        stRelease   = 3'd5,  // Last ack dropping, word completes
        stDone      = 3'd6
    } masterState;

endpackage

// File: rtl/dmaDefs_defs.svh
// Bus, memory, FIFO and handshake size constants for the DMA subsystem
`ifndef DMA_DEFS_SVH
`define DMA_DEFS_SVH

`define ADDR_WIDTH  10   // Byte address on the memory bus
`define MEM_WORDS   256  // 32-bit words in the target

// Upper half of the address space is the 16-bit port
`define NARROW_BIT  9

`define FIFO_DEPTH  8    // Words held by the stream FIFO
`define ACK_DELAY   2    // Target cycles from req to ack
`define COUNT_WIDTH 8    // Block length in words

`endif
